//--- build.f
+incdir+.
lstm_quant_pkg.sv
lstm_ctrl_pkg.sv
lstm_apb_csr.sv
lstm_gate_dot.sv
lstm_gate_act.sv
lstm_cell_update.sv
lstm_top.sv
tb_lstm.sv

//--- lstm_apb_csr.sv
// APB slave of the LSTM cell: register decode, weight and bias write strobes,
// the input vector, and the sequencer that issues the 8 units of one step.
`timescale 1ns/1ps
`include "lstm_macros.svh"

module lstm_apb_csr (
	input  logic                             clk,
	input  logic                             resetn,
	input  logic                             psel,
	input  logic                             penable,
	input  logic                             pwrite,
	input  logic [`LSTM_APB_AW-1:0]          paddr,
	input  logic [31:0]                      pwdata,
	output logic [31:0]                      prdata,
	output logic                             pready,
	output logic                             pslverr,
	input  logic                             step_commit,
	input  lstm_quant_pkg::q8_t              h_vec [0:`LSTM_HIDDEN-1],
	input  lstm_quant_pkg::q8_t              c_vec [0:`LSTM_HIDDEN-1],
	output logic                             w_we,
	output logic [`LSTM_W_AW-1:0]            w_addr,
	output logic [31:0]                      w_data,
	output logic                             b_we,
	output logic [`LSTM_B_AW-1:0]            b_addr,
	output lstm_quant_pkg::bias_t            b_data,
	output logic                             issue_valid,
	output lstm_quant_pkg::unit_idx_t        issue_unit,
	output lstm_quant_pkg::q8_t              x_vec [0:`LSTM_HIDDEN-1],
	output logic                             state_clear
);

	lstm_ctrl_pkg::step_state_e state;
	lstm_quant_pkg::unit_idx_t unit_cnt;
	logic done;
	logic busy;
	logic access;
	logic wr_ok;
	logic rd;
	logic start;
	logic in_w;
	logic in_b;
	logic win_hit;
	logic csr_hit;
	logic sel_ctrl;
	logic sel_x_lo;
	logic sel_x_hi;
	logic [31:0] rdata;
	logic [`LSTM_APB_AW-1:0] w_off;
	logic [`LSTM_APB_AW-1:0] b_off;

	// Byte k of word half is element 4*half+k
	function automatic logic [31:0] pack_word(input lstm_quant_pkg::q8_t v [0:`LSTM_HIDDEN-1],
		input int half);
		return {v[4*half+3], v[4*half+2], v[4*half+1], v[4*half]};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////////////

	assign access = psel && penable;
	assign rd = access && !pwrite;
	assign wr_ok = access && pwrite && !busy;
	assign busy = (state != lstm_ctrl_pkg::ST_IDLE);

	assign w_off = paddr - `LSTM_W_BASE;
	assign b_off = paddr - `LSTM_B_BASE;
	assign in_w = (paddr >= `LSTM_W_BASE) && (paddr < `LSTM_W_BASE + (1 << (`LSTM_W_AW + 2)));
	assign in_b = (paddr >= `LSTM_B_BASE) && (paddr < `LSTM_B_BASE + (1 << (`LSTM_B_AW + 2)));
	assign win_hit = in_w || in_b;

	always_comb begin
		csr_hit = 1'b0;
		sel_ctrl = 1'b0;
		sel_x_lo = 1'b0;
		sel_x_hi = 1'b0;
		rdata = 32'd0;
		if (paddr[`LSTM_APB_AW-1:8] == '0) begin
			csr_hit = 1'b1;
			case (paddr[7:0])
				lstm_ctrl_pkg::CSR_CTRL: begin
					sel_ctrl = 1'b1;
				end
				lstm_ctrl_pkg::CSR_STATUS: begin
					rdata = {30'd0, done, busy};
				end
				lstm_ctrl_pkg::CSR_X_LO: begin
					sel_x_lo = 1'b1;
					rdata = pack_word(x_vec, 0);
				end
				lstm_ctrl_pkg::CSR_X_HI: begin
					sel_x_hi = 1'b1;
					rdata = pack_word(x_vec, 1);
				end
				lstm_ctrl_pkg::CSR_H_LO: rdata = pack_word(h_vec, 0);
				lstm_ctrl_pkg::CSR_H_HI: rdata = pack_word(h_vec, 1);
				lstm_ctrl_pkg::CSR_C_LO: rdata = pack_word(c_vec, 0);
				lstm_ctrl_pkg::CSR_C_HI: rdata = pack_word(c_vec, 1);
				default: csr_hit = 1'b0;
			endcase
		end
	end

	// Zero wait states
	assign pready = 1'b1;
	assign prdata = (rd && csr_hit) ? rdata : 32'd0;

	// Unmapped, read of a write-only window, or a locked write while busy
	assign pslverr = access && (!(csr_hit || win_hit) || (!pwrite && win_hit) ||
		(pwrite && busy && (win_hit || sel_ctrl || sel_x_lo || sel_x_hi)));

	// Memory strobes live only in the access cycle
	assign w_we = wr_ok && in_w;
	assign w_addr = w_off[`LSTM_W_AW+1:2];
	assign w_data = pwdata;
	assign b_we = wr_ok && in_b;
	assign b_addr = b_off[`LSTM_B_AW+1:2];
	assign b_data = pwdata[15:0];

	assign start = wr_ok && sel_ctrl && pwdata[lstm_ctrl_pkg::CTRL_START];
	// Same cycle as the write so a start in the same word sees cleared state
	assign state_clear = wr_ok && sel_ctrl && pwdata[lstm_ctrl_pkg::CTRL_CLEAR];

	////////////////////////////////////////////////////////////////////////////
	// Input vector
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			for (int k = 0; k < `LSTM_INPUT; k++) begin
				x_vec[k] <= '0;
			end
		end else if (wr_ok && (sel_x_lo || sel_x_hi)) begin
			for (int k = 0; k < 4; k++) begin
				x_vec[(sel_x_hi ? 4 : 0) + k] <= pwdata[8*k +: 8];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Step sequencer
	////////////////////////////////////////////////////////////////////////////

	assign issue_valid = (state == lstm_ctrl_pkg::ST_ISSUE);
	assign issue_unit = unit_cnt;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= lstm_ctrl_pkg::ST_IDLE;
			unit_cnt <= '0;
			done <= 1'b0;
		end else begin
			case (state)
				lstm_ctrl_pkg::ST_IDLE: begin
					if (start) begin
						state <= lstm_ctrl_pkg::ST_ISSUE;
						unit_cnt <= '0;
						done <= 1'b0;
					end
				end
				lstm_ctrl_pkg::ST_ISSUE: begin
					unit_cnt <= unit_cnt + 3'd1;
					if (unit_cnt == lstm_quant_pkg::unit_idx_t'(`LSTM_HIDDEN - 1)) begin
						state <= lstm_ctrl_pkg::ST_DRAIN;
					end
				end
				lstm_ctrl_pkg::ST_DRAIN: begin
					// Last unit has left stage 3
					if (step_commit) begin
						state <= lstm_ctrl_pkg::ST_IDLE;
						done <= 1'b1;
					end
				end
				default: state <= lstm_ctrl_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

//--- lstm_cell_update.sv
// Stage 3 of the LSTM pipeline. Holds the c and h state, updates c in place
// and collects the new h of a step, committing it after the last unit.
`timescale 1ns/1ps
`include "lstm_macros.svh"

module lstm_cell_update (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      s2_valid,
	input  lstm_quant_pkg::unit_idx_t s2_unit,
	input  lstm_quant_pkg::q8_t       s2_i,
	input  lstm_quant_pkg::q8_t       s2_f,
	input  lstm_quant_pkg::q8_t       s2_g,
	input  lstm_quant_pkg::q8_t       s2_o,
	input  logic                      state_clear,
	output lstm_quant_pkg::q8_t       h_vec [0:`LSTM_HIDDEN-1],
	output lstm_quant_pkg::q8_t       c_vec [0:`LSTM_HIDDEN-1],
	output logic                      step_commit
);

	lstm_quant_pkg::q8_t h_pend [0:`LSTM_HIDDEN-2];
	lstm_quant_pkg::q8_t c_new;
	lstm_quant_pkg::q8_t h_new;
	logic signed [31:0] fc;
	logic signed [31:0] ig;
	logic signed [31:0] c_sum;
	logic signed [31:0] oh;
	logic last_unit;

	assign last_unit = (s2_unit == lstm_quant_pkg::unit_idx_t'(`LSTM_HIDDEN - 1));

	// c' = (f*c + (i*g >> 2)) >> 7, h' = (o * tanh(c')) >> 9
	always_comb begin
		fc = s2_f * c_vec[s2_unit];
		ig = s2_i * s2_g;
		c_sum = (fc + (ig >>> `LSTM_IG_SHIFT)) >>> `LSTM_C_SHIFT;
		c_new = lstm_quant_pkg::clamp_q8(c_sum, -128, 127);
		oh = s2_o * lstm_quant_pkg::hard_tanh(c_new);
		h_new = lstm_quant_pkg::clamp_q8(oh >>> `LSTM_H_SHIFT, -128, 127);
	end

	////////////////////////////////////////////////////////////////////////////
	// State arrays
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			for (int u = 0; u < `LSTM_HIDDEN; u++) begin
				c_vec[u] <= '0;
				h_vec[u] <= '0;
			end
			for (int u = 0; u < `LSTM_HIDDEN - 1; u++) begin
				h_pend[u] <= '0;
			end
			step_commit <= 1'b0;
		end else if (state_clear) begin
			for (int u = 0; u < `LSTM_HIDDEN; u++) begin
				c_vec[u] <= '0;
				h_vec[u] <= '0;
			end
			for (int u = 0; u < `LSTM_HIDDEN - 1; u++) begin
				h_pend[u] <= '0;
			end
			step_commit <= 1'b0;
		end else begin
			step_commit <= 1'b0;
			if (s2_valid) begin
				c_vec[s2_unit] <= c_new;
				if (last_unit) begin
					// Earlier units of the step kept reading the old h
					for (int u = 0; u < `LSTM_HIDDEN - 1; u++) begin
						h_vec[u] <= h_pend[u];
					end
					h_vec[`LSTM_HIDDEN-1] <= h_new;
					step_commit <= 1'b1;
				end else begin
					h_pend[s2_unit] <= h_new;
				end
			end
		end
	end

endmodule

//--- lstm_ctrl_pkg.sv
// Register map and step sequencer encodings of the APB control block.
// Shared between the CSR slave and the testbench.
package lstm_ctrl_pkg;

	// Byte offsets of the control registers
	typedef enum logic [7:0] {
		CSR_CTRL   = 8'h00,
		CSR_STATUS = 8'h04,
		CSR_X_LO   = 8'h08,
		CSR_X_HI   = 8'h0C,
		CSR_H_LO   = 8'h10,
		CSR_H_HI   = 8'h14,
		CSR_C_LO   = 8'h18,
		CSR_C_HI   = 8'h1C
	} csr_addr_e;

	// CTRL bit positions
	typedef enum int {
		CTRL_START = 0,
		CTRL_CLEAR = 1
	} ctrl_bit_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_DRAIN
	} step_state_e;

endpackage

//--- lstm_gate_act.sv
// Stage 2 of the LSTM pipeline. Requantizes the gate pre-sums to 8 bits and
// applies hard sigmoid to I, F, O and hard tanh to the cell candidate G.
`timescale 1ns/1ps
`include "lstm_macros.svh"

module lstm_gate_act (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      s1_valid,
	input  lstm_quant_pkg::unit_idx_t s1_unit,
	input  lstm_quant_pkg::acc_t      s1_pre [0:`LSTM_GATES-1],
	output logic                      s2_valid,
	output lstm_quant_pkg::unit_idx_t s2_unit,
	output lstm_quant_pkg::q8_t       s2_i,
	output lstm_quant_pkg::q8_t       s2_f,
	output lstm_quant_pkg::q8_t       s2_g,
	output lstm_quant_pkg::q8_t       s2_o
);

	lstm_quant_pkg::q8_t p [0:`LSTM_GATES-1];

	// Hard sigmoid, 64 is one half, 127 saturates near one
	function automatic lstm_quant_pkg::q8_t hard_sigmoid(input lstm_quant_pkg::q8_t v);
		return lstm_quant_pkg::clamp_q8(64 + v, 0, 127);
	endfunction

	// Accumulator scale down to the activation input scale
	always_comb begin
		for (int g = 0; g < `LSTM_GATES; g++) begin
			p[g] = lstm_quant_pkg::clamp_q8(s1_pre[g] >>> `LSTM_ACC_SHIFT, -128, 127);
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			s2_valid <= 1'b0;
		end else begin
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			s2_unit <= s1_unit;
			s2_i <= hard_sigmoid(p[lstm_quant_pkg::GATE_I]);
			s2_f <= hard_sigmoid(p[lstm_quant_pkg::GATE_F]);
			s2_g <= lstm_quant_pkg::hard_tanh(p[lstm_quant_pkg::GATE_G]);
			s2_o <= hard_sigmoid(p[lstm_quant_pkg::GATE_O]);
		end
	end

endmodule

//--- lstm_gate_dot.sv
// Stage 1 of the LSTM pipeline. Holds the weight and bias memories and forms
// the four biased inner products of the issued unit over x followed by h.
`timescale 1ns/1ps
`include "lstm_macros.svh"

module lstm_gate_dot (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      w_we,
	input  logic [`LSTM_W_AW-1:0]     w_addr,
	input  logic [31:0]               w_data,
	input  logic                      b_we,
	input  logic [`LSTM_B_AW-1:0]     b_addr,
	input  lstm_quant_pkg::bias_t     b_data,
	input  logic                      issue_valid,
	input  lstm_quant_pkg::unit_idx_t issue_unit,
	input  lstm_quant_pkg::q8_t       x_vec [0:`LSTM_INPUT-1],
	input  lstm_quant_pkg::q8_t       h_vec [0:`LSTM_HIDDEN-1],
	output logic                      s1_valid,
	output lstm_quant_pkg::unit_idx_t s1_unit,
	output lstm_quant_pkg::acc_t      s1_pre [0:`LSTM_GATES-1]
);

	lstm_quant_pkg::q8_t w_mem [0:`LSTM_HIDDEN-1][0:`LSTM_GATES-1][0:`LSTM_TERMS-1];
	lstm_quant_pkg::bias_t b_mem [0:`LSTM_HIDDEN-1][0:`LSTM_GATES-1];
	lstm_quant_pkg::q8_t opnd [0:`LSTM_TERMS-1];
	lstm_quant_pkg::acc_t pre [0:`LSTM_GATES-1];

	// Weight word: unit[6:4] gate[3:2] word[1:0], byte k is term 4*word+k
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			for (int u = 0; u < `LSTM_HIDDEN; u++) begin
				for (int g = 0; g < `LSTM_GATES; g++) begin
					b_mem[u][g] <= '0;
					for (int t = 0; t < `LSTM_TERMS; t++) begin
						w_mem[u][g][t] <= '0;
					end
				end
			end
		end else begin
			if (w_we) begin
				for (int k = 0; k < 4; k++) begin
					w_mem[w_addr[6:4]][w_addr[3:2]][4*w_addr[1:0] + k] <= w_data[8*k +: 8];
				end
			end
			if (b_we) begin
				b_mem[b_addr[4:2]][b_addr[1:0]] <= b_data;
			end
		end
	end

	// Terms 0..7 from x, 8..15 from the committed h
	always_comb begin
		for (int t = 0; t < `LSTM_INPUT; t++) begin
			opnd[t] = x_vec[t];
		end
		for (int t = 0; t < `LSTM_HIDDEN; t++) begin
			opnd[`LSTM_INPUT + t] = h_vec[t];
		end
	end

	always_comb begin
		for (int g = 0; g < `LSTM_GATES; g++) begin
			pre[g] = lstm_quant_pkg::acc_t'(b_mem[issue_unit][g]);
			for (int t = 0; t < `LSTM_TERMS; t++) begin
				pre[g] = pre[g] + lstm_quant_pkg::acc_t'(w_mem[issue_unit][g][t]) *
					lstm_quant_pkg::acc_t'(opnd[t]);
			end
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= issue_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			s1_unit <= issue_unit;
			for (int g = 0; g < `LSTM_GATES; g++) begin
				s1_pre[g] <= pre[g];
			end
		end
	end

endmodule

//--- lstm_macros.svh
// Sizes, fixed-point shifts and APB address map of the quantized LSTM cell.
// Included by every RTL file that needs a dimension or an address base.
`ifndef LSTM_MACROS_SVH
`define LSTM_MACROS_SVH

// Network dimensions
`define LSTM_HIDDEN 8
`define LSTM_INPUT 8
`define LSTM_TERMS 16
`define LSTM_GATES 4

// Requantization shifts, all arithmetic
`define LSTM_ACC_SHIFT 7
`define LSTM_IG_SHIFT 2
`define LSTM_C_SHIFT 7
`define LSTM_H_SHIFT 9

// APB map
`define LSTM_APB_AW 12
`define LSTM_W_BASE 12'h100
`define LSTM_B_BASE 12'h300

// Word address widths of the two write-only windows
`define LSTM_W_AW 7
`define LSTM_B_AW 5

// Issue to commit stages
`define LSTM_PIPE_DEPTH 3

`endif

//--- lstm_quant_pkg.sv
// Quantized data types, gate selector and the shared clamp helpers.
// Every datapath block and the testbench refer to these by scoped name.
package lstm_quant_pkg;

	typedef logic signed [7:0] q8_t;
	typedef logic signed [15:0] bias_t;
	typedef logic signed [23:0] acc_t;
	typedef logic [2:0] unit_idx_t;

	// Row select inside a unit's weights and biases
	typedef enum logic [1:0] {
		GATE_I,
		GATE_F,
		GATE_G,
		GATE_O
	} gate_e;

	function automatic q8_t clamp_q8(input logic signed [31:0] v, input int lo, input int hi);
		q8_t r;
		if (v < lo) begin
			r = q8_t'(lo);
		end else if (v > hi) begin
			r = q8_t'(hi);
		end else begin
			r = q8_t'(v);
		end
		return r;
	endfunction

	// Hard tanh, slope 4, symmetric range
	function automatic q8_t hard_tanh(input q8_t p);
		return clamp_q8(4 * p, -127, 127);
	endfunction

endpackage

//--- lstm_top.sv
// Top level of the quantized LSTM cell. APB slave in front of the
// dot product, activation and cell update stages.
`timescale 1ns/1ps
`include "lstm_macros.svh"

module lstm_top (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [`LSTM_APB_AW-1:0] paddr,
	input  logic [31:0]             pwdata,
	output logic [31:0]             prdata,
	output logic                    pready,
	output logic                    pslverr
);

	// CSR to stage 1
	logic w_we;
	logic [`LSTM_W_AW-1:0] w_addr;
	logic [31:0] w_data;
	logic b_we;
	logic [`LSTM_B_AW-1:0] b_addr;
	lstm_quant_pkg::bias_t b_data;
	logic issue_valid;
	lstm_quant_pkg::unit_idx_t issue_unit;
	lstm_quant_pkg::q8_t x_vec [0:`LSTM_INPUT-1];

	// Pipeline
	logic s1_valid;
	lstm_quant_pkg::unit_idx_t s1_unit;
	lstm_quant_pkg::acc_t s1_pre [0:`LSTM_GATES-1];
	logic s2_valid;
	lstm_quant_pkg::unit_idx_t s2_unit;
	lstm_quant_pkg::q8_t s2_i;
	lstm_quant_pkg::q8_t s2_f;
	lstm_quant_pkg::q8_t s2_g;
	lstm_quant_pkg::q8_t s2_o;

	// Committed state and control back to the CSR
	lstm_quant_pkg::q8_t h_vec [0:`LSTM_HIDDEN-1];
	lstm_quant_pkg::q8_t c_vec [0:`LSTM_HIDDEN-1];
	logic step_commit;
	logic state_clear;

	lstm_apb_csr u_csr (
		.clk(clk), .resetn(resetn),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.step_commit(step_commit), .h_vec(h_vec), .c_vec(c_vec),
		.w_we(w_we), .w_addr(w_addr), .w_data(w_data),
		.b_we(b_we), .b_addr(b_addr), .b_data(b_data),
		.issue_valid(issue_valid), .issue_unit(issue_unit), .x_vec(x_vec),
		.state_clear(state_clear)
	);

	lstm_gate_dot u_gate_dot (
		.clk(clk), .resetn(resetn),
		.w_we(w_we), .w_addr(w_addr), .w_data(w_data),
		.b_we(b_we), .b_addr(b_addr), .b_data(b_data),
		.issue_valid(issue_valid), .issue_unit(issue_unit), .x_vec(x_vec), .h_vec(h_vec),
		.s1_valid(s1_valid), .s1_unit(s1_unit), .s1_pre(s1_pre)
	);

	lstm_gate_act u_gate_act (
		.clk(clk), .resetn(resetn),
		.s1_valid(s1_valid), .s1_unit(s1_unit), .s1_pre(s1_pre),
		.s2_valid(s2_valid), .s2_unit(s2_unit),
		.s2_i(s2_i), .s2_f(s2_f), .s2_g(s2_g), .s2_o(s2_o)
	);

	lstm_cell_update u_cell_update (
		.clk(clk), .resetn(resetn),
		.s2_valid(s2_valid), .s2_unit(s2_unit),
		.s2_i(s2_i), .s2_f(s2_f), .s2_g(s2_g), .s2_o(s2_o),
		.state_clear(state_clear),
		.h_vec(h_vec), .c_vec(c_vec), .step_commit(step_commit)
	);

endmodule

//--- tb_lstm.sv
// Testbench for the quantized LSTM cell. Drives the APB slave with random
// weights and inputs and checks h, c, status and bus errors against a model.
`timescale 1ns/1ps
`include "lstm_macros.svh"

module tb_lstm;

	localparam logic [31:0] SEED = 32'he7a0_6418;
	// One APB transfer takes 3 clocks and a weight load 5 words per gate
	localparam int LOAD_CYCLES = 3 * (`LSTM_HIDDEN * `LSTM_GATES * 5);
	localparam int STEP_CYCLES = 80;
	localparam int MAX_CYCLES = 10 * (2 * LOAD_CYCLES + 12 * STEP_CYCLES);

	logic clk;
	logic resetn;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`LSTM_APB_AW-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	int cycle_count;

	// Reference state
	lstm_quant_pkg::q8_t m_w [0:`LSTM_HIDDEN-1][0:`LSTM_GATES-1][0:`LSTM_TERMS-1];
	lstm_quant_pkg::bias_t m_b [0:`LSTM_HIDDEN-1][0:`LSTM_GATES-1];
	lstm_quant_pkg::q8_t m_x [0:`LSTM_INPUT-1];
	lstm_quant_pkg::q8_t m_h [0:`LSTM_HIDDEN-1];
	lstm_quant_pkg::q8_t m_c [0:`LSTM_HIDDEN-1];

	lstm_top u_lstm_top (
		.clk(clk), .resetn(resetn),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("RESULT: FAIL");
			$fatal(1, "simulation stopped by timeout");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_q8(input string name, input lstm_quant_pkg::q8_t got,
		input lstm_quant_pkg::q8_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "flag mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// APB master sampling on the falling edge of the access cycle
	////////////////////////////////////////////////////////////////////////////

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check_flag("pready", pready, 1'b1);
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check_flag("pready", pready, 1'b1);
		data = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic int saturate(input int v, input int lo, input int hi);
		if (v < lo) begin
			return lo;
		end
		if (v > hi) begin
			return hi;
		end
		return v;
	endfunction

	function automatic int rand_between(input int lo, input int hi);
		return lo + int'($urandom_range(hi - lo));
	endfunction

	// All units read the old h while c updates in place per unit
	task automatic model_step();
		int pre;
		int p [0:`LSTM_GATES-1];
		int gi;
		int gf;
		int gg;
		int go;
		int c_next;
		int h_next [0:`LSTM_HIDDEN-1];
		for (int u = 0; u < `LSTM_HIDDEN; u++) begin
			for (int g = 0; g < `LSTM_GATES; g++) begin
				pre = int'(m_b[u][g]);
				for (int t = 0; t < `LSTM_INPUT; t++) begin
					pre = pre + int'(m_w[u][g][t]) * int'(m_x[t]);
				end
				for (int t = 0; t < `LSTM_HIDDEN; t++) begin
					pre = pre + int'(m_w[u][g][`LSTM_INPUT + t]) * int'(m_h[t]);
				end
				p[g] = saturate(pre >>> `LSTM_ACC_SHIFT, -128, 127);
			end
			gi = saturate(64 + p[lstm_quant_pkg::GATE_I], 0, 127);
			gf = saturate(64 + p[lstm_quant_pkg::GATE_F], 0, 127);
			go = saturate(64 + p[lstm_quant_pkg::GATE_O], 0, 127);
			gg = saturate(4 * p[lstm_quant_pkg::GATE_G], -127, 127);
			c_next = gf * int'(m_c[u]) + ((gi * gg) >>> `LSTM_IG_SHIFT);
			c_next = saturate(c_next >>> `LSTM_C_SHIFT, -128, 127);
			h_next[u] = go * saturate(4 * c_next, -127, 127);
			h_next[u] = saturate(h_next[u] >>> `LSTM_H_SHIFT, -128, 127);
			m_c[u] = lstm_quant_pkg::q8_t'(c_next);
		end
		for (int u = 0; u < `LSTM_HIDDEN; u++) begin
			m_h[u] = lstm_quant_pkg::q8_t'(h_next[u]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequences
	////////////////////////////////////////////////////////////////////////////

	// Weight words by {unit, gate, word} and one bias per unit and gate
	task automatic load_weights(input int lo, input int hi, input int blo, input int bhi);
		logic [31:0] word;
		logic err;
		for (int u = 0; u < `LSTM_HIDDEN; u++) begin
			for (int g = 0; g < `LSTM_GATES; g++) begin
				for (int w = 0; w < 4; w++) begin
					for (int k = 0; k < 4; k++) begin
						m_w[u][g][4*w + k] = lstm_quant_pkg::q8_t'(rand_between(lo, hi));
						word[8*k +: 8] = m_w[u][g][4*w + k];
					end
					apb_write(`LSTM_W_BASE + 12'((u * 16 + g * 4 + w) * 4), word, err);
					check_flag("pslverr", err, 1'b0);
				end
				m_b[u][g] = lstm_quant_pkg::bias_t'(rand_between(blo, bhi));
				apb_write(`LSTM_B_BASE + 12'((u * 4 + g) * 4), {16'd0, m_b[u][g]}, err);
				check_flag("pslverr", err, 1'b0);
			end
		end
	endtask

	task automatic write_x();
		logic [31:0] word;
		logic err;
		for (int half = 0; half < 2; half++) begin
			for (int k = 0; k < 4; k++) begin
				m_x[4*half + k] = lstm_quant_pkg::q8_t'(rand_between(-64, 63));
				word[8*k +: 8] = m_x[4*half + k];
			end
			apb_write(lstm_ctrl_pkg::CSR_X_LO + 12'(4 * half), word, err);
			check_flag("pslverr", err, 1'b0);
		end
	endtask

	// H_LO, H_HI, C_LO, C_HI in order
	task automatic check_state();
		logic [31:0] data;
		logic err;
		for (int r = 0; r < 4; r++) begin
			apb_read(lstm_ctrl_pkg::CSR_H_LO + 12'(4 * r), data, err);
			check_flag("pslverr", err, 1'b0);
			for (int k = 0; k < 4; k++) begin
				if (r < 2) begin
					check_q8($sformatf("h[%0d]", 4*r + k), data[8*k +: 8], m_h[4*r + k]);
				end else begin
					check_q8($sformatf("c[%0d]", 4*(r-2) + k), data[8*k +: 8],
						m_c[4*(r-2) + k]);
				end
			end
		end
	endtask

	task automatic wait_idle(output logic [31:0] status);
		logic err;
		status = 32'h1;
		while (status[0]) begin
			apb_read(lstm_ctrl_pkg::CSR_STATUS, status, err);
			check_flag("pslverr", err, 1'b0);
		end
	endtask

	task automatic run_step();
		logic [31:0] status;
		logic err;
		write_x();
		apb_write(lstm_ctrl_pkg::CSR_CTRL, 32'h1, err);
		check_flag("pslverr", err, 1'b0);
		model_step();
		wait_idle(status);
		check_flag("status.done", status[1], 1'b1);
		check_state();
	endtask

	initial begin
		logic [31:0] data;
		logic err;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		resetn = 1'b0;
		cycle_count = 0;
		void'($urandom(SEED));
		for (int u = 0; u < `LSTM_HIDDEN; u++) begin
			m_x[u] = '0;
			m_h[u] = '0;
			m_c[u] = '0;
		end
		repeat (10) @(posedge clk);
		resetn <= 1'b1;

		// State and status are clear out of reset
		check_state();
		apb_read(lstm_ctrl_pkg::CSR_STATUS, data, err);
		check_flag("pslverr", err, 1'b0);
		check_flag("status.busy", data[0], 1'b0);
		check_flag("status.done", data[1], 1'b0);

		// Small weights with state carried over six steps
		load_weights(-16, 15, -4096, 4095);
		repeat (6) run_step();

		// Full range weights drive the clamps
		load_weights(-128, 127, -32768, 32767);
		repeat (2) run_step();

		// Start access lands on edge A, X write on A+3, weight write on A+6
		write_x();
		apb_write(lstm_ctrl_pkg::CSR_CTRL, 32'h1, err);
		check_flag("pslverr", err, 1'b0);
		apb_write(lstm_ctrl_pkg::CSR_X_LO, 32'h5a5a_5a5a, err);
		check_flag("pslverr", err, 1'b1);
		apb_write(`LSTM_W_BASE, 32'h7f7f_7f7f, err);
		check_flag("pslverr", err, 1'b1);
		// Status sampled after A+10 in the last busy cycle
		repeat (2) @(posedge clk);
		apb_read(lstm_ctrl_pkg::CSR_STATUS, data, err);
		check_flag("status.busy", data[0], 1'b1);
		check_flag("status.done", data[1], 1'b0);
		model_step();
		wait_idle(data);
		check_state();
		apb_read(lstm_ctrl_pkg::CSR_X_LO, data, err);
		check_flag("pslverr", err, 1'b0);
		for (int k = 0; k < 4; k++) begin
			check_q8($sformatf("x[%0d]", k), data[8*k +: 8], m_x[k]);
		end

		// Status sampled after A+11 has busy low again
		apb_write(lstm_ctrl_pkg::CSR_CTRL, 32'h1, err);
		check_flag("pslverr", err, 1'b0);
		model_step();
		repeat (9) @(posedge clk);
		apb_read(lstm_ctrl_pkg::CSR_STATUS, data, err);
		check_flag("status.busy", data[0], 1'b0);
		check_flag("status.done", data[1], 1'b1);
		check_state();

		// Clear while idle and then bus errors on unmapped and write-only reads
		apb_write(lstm_ctrl_pkg::CSR_CTRL, 32'h2, err);
		check_flag("pslverr", err, 1'b0);
		for (int u = 0; u < `LSTM_HIDDEN; u++) begin
			m_h[u] = '0;
			m_c[u] = '0;
		end
		check_state();
		apb_read(12'h040, data, err);
		check_flag("pslverr", err, 1'b1);
		apb_read(`LSTM_W_BASE, data, err);
		check_flag("pslverr", err, 1'b1);
		run_step();

		$display("RESULT: PASS");
		$finish;
	end

endmodule
